// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, then search the log for a failure
rm -f sim.log
verilator --binary --assert --timescale 1ns/1ns --top-module icache_tb \
        -f sim.f -o icache_sim \
    && { ./obj_dir/icache_sim > sim.log 2>&1; cat sim.log; } \
    && ! grep -q -e "TESTS FAILED" -e "%Error" sim.log \
    && grep -q "TESTS PASSED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== sim.f ====
+incdir+src
src/mem_msg_pkg.sv
src/icache_pkg.sv
src/msg_queue.sv
src/queue_arbitrator.sv
src/cache_bank.sv
src/icache_top.sv
testbench/icache_assertions.sv
testbench/icache_tb.sv

// ==== src/cache_bank.sv ====
`timescale 1ns/1ns
`include "icache_defs.svh"

module cache_bank
    import mem_msg_pkg::*, icache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  cache_req_t  req,
    input  logic        mem_full,
    output lookup_rsp_t rsp,
    output logic        miss_alloc,
    output miss_req_t   miss_out,
    output logic        stall
);
    localparam int LINE_BITS = 32 - `OFF_BITS;

    // Direct mapped storage
    logic                 valid_arr [`IDX_CNT];
    logic [`TAG_SIZE-1:0] tag_arr   [`IDX_CNT];
    logic [`CL_SIZE-1:0]  line_arr  [`IDX_CNT];

    logic [`IDX_BITS-1:0] idx;
    logic [`TAG_SIZE-1:0] tag;
    logic [LINE_BITS-1:0] req_line_addr;
    logic                 is_fetch;
    logic                 is_fill;
    logic                 is_inval;
    logic                 tag_match;
    logic                 new_miss;
    logic                 fill_done;

    // Outstanding miss
    logic                 miss_pending;
    logic                 miss_sent;
    logic [LINE_BITS-1:0] miss_line;

    assign idx           = req.addr[`OFF_BITS +: `IDX_BITS];
    assign tag           = req.addr[31 -: `TAG_SIZE];
    assign req_line_addr = req.addr[31:`OFF_BITS];

    assign is_fetch = req.valid && (req.kind == FETCH);
    assign is_fill  = req.valid && (req.kind == FILL);
    assign is_inval = req.valid && (req.kind == INVAL);

    assign tag_match = valid_arr[idx] && (tag_arr[idx] == tag);

    // Later misses only report hit low while one is outstanding
    assign new_miss  = is_fetch && !tag_match && !miss_pending;
    assign fill_done = is_fill && miss_pending && (req_line_addr == miss_line);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `IDX_CNT; i++) begin
                valid_arr[i] <= 1'b0;
            end
        end else if (is_fill) begin
            valid_arr[idx] <= 1'b1;
        end else if (is_inval && tag_match) begin
            valid_arr[idx] <= 1'b0;   // Different tag leaves the set alone
        end
    end

    always_ff @(posedge clk) begin
        if (is_fill) begin
            tag_arr[idx]  <= tag;
            line_arr[idx] <= req.line;
        end
    end

    // Second lookup cycle registers the compare result
    always_ff @(posedge clk) begin
        rsp.hit  <= is_fetch && tag_match;
        rsp.addr <= req.addr;
        rsp.line <= line_arr[idx];
        if (rst) begin
            rsp.valid <= 1'b0;
        end else begin
            rsp.valid <= is_fetch;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            miss_pending <= 1'b0;
            miss_sent    <= 1'b0;
        end else if (fill_done) begin
            miss_pending <= 1'b0;
            miss_sent    <= 1'b0;
        end else if (new_miss) begin
            miss_pending <= 1'b1;
            miss_sent    <= 1'b0;
        end else if (miss_alloc) begin
            miss_sent <= 1'b1;   // Request taken by memory
        end
    end

    always_ff @(posedge clk) begin
        if (new_miss) begin
            miss_line <= req_line_addr;
        end
    end

    // Request waits here while memory is full
    assign miss_alloc    = miss_pending && !miss_sent && !mem_full;
    assign miss_out.addr = {miss_line, {`OFF_BITS{1'b0}}};
    assign miss_out.op   = RD;

    assign stall = miss_pending;   // Held until the matching fill lands

endmodule

// ==== src/icache_defs.svh ====
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// Cache geometry
`define CL_SIZE  128   // Bits per line
`define IDX_CNT  16    // Number of sets
`define IDX_BITS 4
`define OFF_BITS 4     // Byte offset within a 16 byte line

// Tag is whatever remains of a 32-bit address
`define TAG_SIZE 24

// Memory message queues
`define Q_DEPTH  4

`endif

// ==== src/icache_pkg.sv ====
`include "icache_defs.svh"

package icache_pkg;

    // Which source won arbitration
    typedef enum logic [1:0] {
        FETCH = 2'd0,
        FILL  = 2'd1,
        INVAL = 2'd2
    } req_kind_t;

    // Request stage between the arbitrator and the bank
    typedef struct packed {
        logic                valid;
        req_kind_t           kind;
        logic [31:0]         addr;
        logic [`CL_SIZE-1:0] line;   // Only meaningful for FILL
    } cache_req_t;

    // Lookup result returned to the pipeline
    typedef struct packed {
        logic                valid;
        logic                hit;
        logic [31:0]         addr;   // Address the line belongs to
        logic [`CL_SIZE-1:0] line;
    } lookup_rsp_t;

endpackage

// ==== src/icache_top.sv ====
`timescale 1ns/1ns
`include "icache_defs.svh"

module icache_top
    import mem_msg_pkg::*, icache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // Pipeline side
    input  logic        fetch_valid,
    input  logic [31:0] fetch_addr,
    output lookup_rsp_t rsp,
    output logic        stall,
    // Memory side
    input  logic        fill_alloc,
    input  fill_msg_t   fill_in,
    output logic        fill_full,
    input  logic        inv_alloc,
    input  inv_msg_t    inv_in,
    output logic        inv_full,
    output logic        miss_alloc,
    output miss_req_t   miss_out,
    input  logic        mem_full
);
    fill_msg_t  fill_head;
    logic       fill_valid;
    logic       fill_dealloc;
    inv_msg_t   inv_head;
    logic       inv_valid;
    logic       inv_dealloc;
    cache_req_t req;

    msg_queue #(.entry_t(fill_msg_t)) fill_q (
        .clk        (clk),
        .rst        (rst),
        .alloc      (fill_alloc),
        .entry_in   (fill_in),
        .dealloc    (fill_dealloc),
        .full       (fill_full),
        .head       (fill_head),
        .head_valid (fill_valid)
    );

    msg_queue #(.entry_t(inv_msg_t)) inv_q (
        .clk        (clk),
        .rst        (rst),
        .alloc      (inv_alloc),
        .entry_in   (inv_in),
        .dealloc    (inv_dealloc),
        .full       (inv_full),
        .head       (inv_head),
        .head_valid (inv_valid)
    );

    queue_arbitrator queue_arb (
        .clk          (clk),
        .rst          (rst),
        .fill_head    (fill_head),
        .fill_valid   (fill_valid),
        .inv_head     (inv_head),
        .inv_valid    (inv_valid),
        .fetch_valid  (fetch_valid),
        .fetch_addr   (fetch_addr),
        .stall        (stall),
        .fill_dealloc (fill_dealloc),
        .inv_dealloc  (inv_dealloc),
        .req          (req)
    );

    cache_bank bank (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .mem_full   (mem_full),
        .rsp        (rsp),
        .miss_alloc (miss_alloc),
        .miss_out   (miss_out),
        .stall      (stall)
    );

endmodule

// ==== src/mem_msg_pkg.sv ====
`include "icache_defs.svh"

package mem_msg_pkg;

    // Memory operation codes
    typedef enum logic [2:0] {
        LD  = 3'b001,   // Pipeline load
        RD  = 3'b010,   // Line read toward memory
        WR  = 3'b011,
        INV = 3'b100
    } mem_op_t;

    // Line returned from memory
    typedef struct packed {
        logic [31:0]         addr;
        mem_op_t             op;
        logic [`CL_SIZE-1:0] line;
    } fill_msg_t;

    // Coherence invalidate carrying only an address
    typedef struct packed {
        logic [31:0] addr;
        mem_op_t     op;
    } inv_msg_t;

    // Request sent on a miss
    typedef struct packed {
        logic [31:0] addr;   // Offset bits cleared
        mem_op_t     op;
    } miss_req_t;

endpackage

// ==== src/msg_queue.sv ====
`timescale 1ns/1ns
`include "icache_defs.svh"

module msg_queue
    import mem_msg_pkg::*;
#(
    parameter type entry_t = fill_msg_t
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   alloc,
    input  entry_t entry_in,
    input  logic   dealloc,
    output logic   full,
    output entry_t head,
    output logic   head_valid
);
    localparam int PTR_W = $clog2(`Q_DEPTH);
    localparam logic [PTR_W-1:0] LAST  = PTR_W'(`Q_DEPTH - 1);
    localparam logic [PTR_W:0]   DEPTH = (PTR_W + 1)'(`Q_DEPTH);

    entry_t buffer [`Q_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    // Alloc while full is silently dropped
    assign do_push = alloc && !full;
    assign do_pop  = dealloc && head_valid;

    assign full       = (count == DEPTH);
    assign head_valid = (count != '0);
    assign head       = buffer[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            buffer[wr_ptr] <= entry_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            // Push and pop together leave the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== src/queue_arbitrator.sv ====
`timescale 1ns/1ns
`include "icache_defs.svh"

module queue_arbitrator
    import mem_msg_pkg::*, icache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  fill_msg_t   fill_head,
    input  logic        fill_valid,
    input  inv_msg_t    inv_head,
    input  logic        inv_valid,
    input  logic        fetch_valid,
    input  logic [31:0] fetch_addr,
    input  logic        stall,
    output logic        fill_dealloc,
    output logic        inv_dealloc,
    output cache_req_t  req
);
    logic       grant_fill;
    logic       grant_inv;
    logic       grant_fetch;
    cache_req_t req_d;

    // Memory responses always win over the pipeline
    assign grant_fill  = fill_valid;
    assign grant_inv   = inv_valid && !fill_valid;
    assign grant_fetch = fetch_valid && !stall && !fill_valid && !inv_valid;

    assign fill_dealloc = grant_fill;   // Pop the head we just took
    assign inv_dealloc  = grant_inv;

    always_comb begin
        req_d       = '0;
        req_d.valid = grant_fill || grant_inv || grant_fetch;
        if (grant_fill) begin
            req_d.kind = FILL;
            req_d.addr = fill_head.addr;
            req_d.line = fill_head.line;
        end else if (grant_inv) begin
            req_d.kind = INVAL;
            req_d.addr = inv_head.addr;
        end else begin
            // Fetch or idle leaves the line at zero
            req_d.kind = FETCH;
            req_d.addr = fetch_addr;
        end
    end

    // Request stage toward the bank
    always_ff @(posedge clk) begin
        req <= req_d;
        if (rst) begin
            req.valid <= 1'b0;
        end
    end

endmodule

// ==== testbench/icache_assertions.sv ====
`timescale 1ns/1ns

module icache_assertions (
    input logic clk,
    input logic rst,
    input logic miss_alloc,
    input logic mem_full,
    input logic fill_alloc,
    input logic fill_full,
    input logic stall
);

    // Memory refuses requests while full
    miss_vs_mem_full: assert property (@(posedge clk) disable iff (rst)
        !(miss_alloc && mem_full))
        else $error("miss_alloc high while mem_full is high");

    miss_single_pulse: assert property (@(posedge clk) disable iff (rst)
        miss_alloc |=> !miss_alloc)
        else $error("miss_alloc held for more than one cycle");

    // Alloc into a full queue would be dropped
    fill_vs_full: assert property (@(posedge clk) disable iff (rst)
        !(fill_alloc && fill_full))
        else $error("fill_alloc high while fill_full is high");

    stall_after_reset: assert property (@(posedge clk) $fell(rst) |-> !stall)
        else $error("stall high in the first cycle after reset");

endmodule

bind icache_top icache_assertions bound_checks (.*);

// ==== testbench/icache_tb.sv ====
`timescale 1ns/1ns
`include "icache_defs.svh"

module icache_tb
    import mem_msg_pkg::*, icache_pkg::*;
();
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int FILL_DELAY   = 4;    // Memory latency after a request
    localparam int RSP_LIMIT    = 8;
    localparam int STALL_LIMIT  = 48;
    localparam int DIRECTED_OPS = 12;
    localparam int RANDOM_OPS   = 80;
    localparam int CYCLE_BUDGET = 48;   // Worst case per operation including a mem_full hold
    localparam int WATCHDOG_NS  =
        (RESET_CYCLES + (DIRECTED_OPS + RANDOM_OPS) * CYCLE_BUDGET) * CLK_PERIOD;

    localparam logic [31:0] ADDR_A = 32'h0000_1234;
    localparam logic [31:0] ADDR_B = 32'h0000_5238;   // Same set as A with another tag
    localparam logic [31:0] ADDR_C = 32'h0000_9a70;

    logic        clk;
    logic        rst;
    logic        fetch_valid;
    logic [31:0] fetch_addr;
    lookup_rsp_t rsp;
    logic        stall;
    logic        fill_alloc;
    fill_msg_t   fill_in;
    logic        fill_full;
    logic        inv_alloc;
    inv_msg_t    inv_in;
    logic        inv_full;
    logic        miss_alloc;
    miss_req_t   miss_out;
    logic        mem_full;

    // Expected valid bit and tag per set
    logic                 model_valid [`IDX_CNT];
    logic [`TAG_SIZE-1:0] model_tag   [`IDX_CNT];

    logic [31:0] exp_addr_q [$];   // Read in order by the checker
    logic        exp_hit_q  [$];
    logic [31:0] last_fetch_addr;
    logic [31:0] rng;
    logic        last_hit;
    int          rsp_cnt;
    int          miss_cnt;
    int          miss_expect;
    int          seq_errors;
    int          rsp_errors;
    int          mem_errors;
    int          timeouts;

    icache_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Word n of a line is the line address plus n
    function automatic logic [`CL_SIZE-1:0] mem_line(input logic [31:0] addr);
        logic [`CL_SIZE-1:0] line;
        logic [31:0]         base;
        base = {addr[31:`OFF_BITS], {`OFF_BITS{1'b0}}};
        for (int w = 0; w < `CL_SIZE / 32; w++) begin
            line[w*32 +: 32] = base + 32'(w);
        end
        return line;
    endfunction

    function automatic logic model_hit(input logic [31:0] addr);
        logic [`IDX_BITS-1:0] set;
        set = addr[`OFF_BITS +: `IDX_BITS];
        return model_valid[set] && (model_tag[set] == addr[31 -: `TAG_SIZE]);
    endfunction

    function automatic void model_fill(input logic [31:0] addr);
        model_valid[addr[`OFF_BITS +: `IDX_BITS]] = 1'b1;
        model_tag[addr[`OFF_BITS +: `IDX_BITS]]   = addr[31 -: `TAG_SIZE];
    endfunction

    function automatic void model_inval(input logic [31:0] addr);
        if (model_hit(addr)) begin
            model_valid[addr[`OFF_BITS +: `IDX_BITS]] = 1'b0;
        end
    endfunction

    // 24 lines over 8 sets with three tags per set
    function automatic logic [31:0] pick_addr(input logic [31:0] r);
        int line_no;
        line_no = int'(r[15:8]) % 24;
        return {24'h000400 + 24'(line_no / 8), 4'(line_no % 8), r[3:0]};
    endfunction

    function automatic void report_mismatch(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
    endfunction

    task automatic expect_hit(input logic want, input string what);
        if (last_hit !== want) begin
            seq_errors++;
            report_mismatch($sformatf("%s gave hit %b, expected %b", what, last_hit, want));
        end
    endtask

    task automatic issue_fetch(input logic [31:0] addr);
        int n;
        n = 0;
        exp_addr_q.push_back(addr);
        exp_hit_q.push_back(model_hit(addr));
        if (!model_hit(addr)) begin
            miss_expect++;
        end
        last_fetch_addr = addr;
        @(posedge clk);
        fetch_valid <= 1'b1;
        fetch_addr  <= addr;
        @(posedge clk);
        fetch_valid <= 1'b0;
        while (rsp_cnt < exp_addr_q.size() && n < RSP_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (rsp_cnt < exp_addr_q.size()) begin
            timeouts++;
            $display("No response to the fetch of %h within %0d cycles", addr, RSP_LIMIT);
        end
    endtask

    // Stall dropping after a miss means the line was served
    task automatic wait_unstalled();
        int n;
        n = 0;
        @(negedge clk);
        while (stall && n < STALL_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (stall) begin
            timeouts++;
            $display("Stall stuck high after the miss on %h", last_fetch_addr);
        end else if (!exp_hit_q[exp_hit_q.size()-1]) begin
            model_fill(last_fetch_addr);
        end
    endtask

    task automatic send_inval(input logic [31:0] addr);
        while (inv_full) begin
            @(negedge clk);
        end
        @(posedge clk);
        inv_alloc   <= 1'b1;
        inv_in.addr <= addr;
        inv_in.op   <= INV;
        @(posedge clk);
        inv_alloc <= 1'b0;
        model_inval(addr);
        repeat (2) @(posedge clk);   // Arbitration and then the valid bit clear
    endtask

    task automatic serve_miss(input logic [31:0] line_addr);
        repeat (FILL_DELAY) begin
            @(negedge clk);
            if (!stall) begin
                mem_errors++;
                report_mismatch("stall low before the fill was sent");
            end
        end
        while (fill_full) begin
            @(negedge clk);
        end
        @(posedge clk);
        fill_alloc   <= 1'b1;
        fill_in.addr <= line_addr;
        fill_in.op   <= RD;
        fill_in.line <= mem_line(line_addr);
        @(posedge clk);
        fill_alloc <= 1'b0;
        @(negedge clk);   // Entry now in the queue
        @(negedge clk);
        if (!stall) begin
            mem_errors++;
            report_mismatch("stall low before the fill reached the arrays");
        end
        @(negedge clk);
        if (stall) begin
            mem_errors++;
            report_mismatch("stall high after the matching fill was written");
        end
    endtask

    // Memory responder
    initial begin
        fill_alloc = 1'b0;
        fill_in    = '0;
        miss_cnt   = 0;
        mem_errors = 0;
        forever begin
            @(negedge clk);
            if (!rst && miss_alloc) begin
                miss_cnt++;
                if (miss_out.addr !== {last_fetch_addr[31:`OFF_BITS], {`OFF_BITS{1'b0}}}) begin
                    mem_errors++;
                    report_mismatch($sformatf("miss_out.addr %h after fetch of %h",
                        miss_out.addr, last_fetch_addr));
                end
                if (miss_out.op !== RD) begin
                    mem_errors++;
                    report_mismatch($sformatf("miss_out.op %0d, expected RD", miss_out.op));
                end
                serve_miss(miss_out.addr);
            end
        end
    end

    // Checker takes one response per fetch in issue order
    initial begin
        rsp_cnt    = 0;
        rsp_errors = 0;
        last_hit   = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && rsp.valid) begin
                if (rsp_cnt >= exp_addr_q.size()) begin
                    rsp_errors++;
                    $display("Response at %0t ns with no fetch outstanding", $time);
                end else begin
                    if (rsp.addr !== exp_addr_q[rsp_cnt]) begin
                        rsp_errors++;
                        report_mismatch($sformatf("rsp.addr %h, expected %h",
                            rsp.addr, exp_addr_q[rsp_cnt]));
                    end
                    if (rsp.hit !== exp_hit_q[rsp_cnt]) begin
                        rsp_errors++;
                        report_mismatch($sformatf("rsp.hit %b for %h, expected %b",
                            rsp.hit, exp_addr_q[rsp_cnt], exp_hit_q[rsp_cnt]));
                    end
                    if (exp_hit_q[rsp_cnt] && rsp.line !== mem_line(exp_addr_q[rsp_cnt])) begin
                        rsp_errors++;
                        report_mismatch($sformatf("rsp.line wrong for %h", exp_addr_q[rsp_cnt]));
                    end
                    last_hit = rsp.hit;
                    rsp_cnt++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int hold;
        int held_misses;
        rst             = 1'b1;
        fetch_valid     = 1'b0;
        fetch_addr      = '0;
        inv_alloc       = 1'b0;
        inv_in          = '0;
        mem_full        = 1'b0;
        rng             = 32'hd0c3;
        last_fetch_addr = '0;
        miss_expect     = 0;
        seq_errors      = 0;
        timeouts        = 0;
        for (int i = 0; i < `IDX_CNT; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i]   = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (rsp.valid !== 1'b0 || stall !== 1'b0 || miss_alloc !== 1'b0
                || fill_full !== 1'b0 || inv_full !== 1'b0) begin
            seq_errors++;
            report_mismatch("rsp.valid, stall, miss_alloc or a full flag high after reset");
        end

        issue_fetch(ADDR_A);   // Cold miss
        expect_hit(1'b0, "first fetch after reset");
        wait_unstalled();
        if (miss_cnt != 1) begin
            seq_errors++;
            report_mismatch($sformatf("%0d miss requests for one cold miss", miss_cnt));
        end
        issue_fetch(ADDR_A);
        expect_hit(1'b1, "fetch of A after its fill");
        issue_fetch(ADDR_A ^ 32'h0000_000c);
        expect_hit(1'b1, "other offset of line A");

        // Conflict within one set
        issue_fetch(ADDR_B);
        expect_hit(1'b0, "fetch of B");
        wait_unstalled();
        issue_fetch(ADDR_B);
        expect_hit(1'b1, "fetch of B after its fill");
        issue_fetch(ADDR_A);
        expect_hit(1'b0, "fetch of A after B replaced it");
        wait_unstalled();

        send_inval(ADDR_A);
        issue_fetch(ADDR_A);
        expect_hit(1'b0, "fetch of A after matching invalidate");
        wait_unstalled();
        send_inval(ADDR_B);
        issue_fetch(ADDR_A);
        expect_hit(1'b1, "fetch of A after invalidate of other tag");

        // Request held back while memory is full
        rng  = lcg_next(rng);
        hold = 2 + int'(rng[19:16]);
        @(posedge clk);
        mem_full <= 1'b1;
        issue_fetch(ADDR_C);
        expect_hit(1'b0, "fetch of C");
        held_misses = miss_cnt;
        repeat (hold) begin
            @(negedge clk);
            if (miss_alloc) begin
                seq_errors++;
                report_mismatch("miss_alloc high while mem_full is held");
            end
        end
        @(posedge clk);
        mem_full <= 1'b0;
        wait_unstalled();
        if (miss_cnt != held_misses + 1) begin
            seq_errors++;
            report_mismatch($sformatf("%0d requests after release of mem_full",
                miss_cnt - held_misses));
        end

        for (int k = 0; k < RANDOM_OPS; k++) begin
            rng = lcg_next(rng);
            if (rng[31:29] == 3'd0) begin
                send_inval(pick_addr(rng));
            end else begin
                issue_fetch(pick_addr(rng));
                wait_unstalled();
            end
        end

        if (miss_cnt != miss_expect) begin
            seq_errors++;
            report_mismatch($sformatf("%0d miss requests, expected %0d", miss_cnt, miss_expect));
        end
        repeat (2) @(negedge clk);
        $display("Responses %0d, errors: sequence %0d, response %0d, memory %0d, timeouts %0d",
            rsp_cnt, seq_errors, rsp_errors, mem_errors, timeouts);
        if (seq_errors + rsp_errors + mem_errors + timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
